// File: logic/clip_pkg.sv
package clip_pkg;

    localparam int coord_w = 16;
    localparam int color_w = 3;
    localparam int obj_w = 4 * coord_w + color_w;  // x0 y0 x1 y1 colour, x0 lowest
    localparam int ent_w = obj_w + 8;              // record plus oc0 and oc1
    localparam int pix_w = 10;
    localparam int out_w = 4 * pix_w + color_w;

    // outcode bit positions
    localparam logic [1:0] oc_top = 2'd3;
    localparam logic [1:0] oc_bottom = 2'd2;
    localparam logic [1:0] oc_right = 2'd1;
    localparam logic [1:0] oc_left = 2'd0;

    typedef enum logic [2:0] {
        st_idle,
        st_pop,
        st_judge,
        st_clip,
        st_store,
        st_drop
    } ctrl_state_t;

    typedef enum logic [1:0] {
        step_idle,
        step_setup,
        step_divide,
        step_update
    } clip_step_t;

    function automatic logic [3:0] outcode(input logic signed [coord_w-1:0] x,
                                           input logic signed [coord_w-1:0] y,
                                           input int xm, input int ym);
        logic [3:0] oc;
        oc = 4'd0;
        oc[oc_top] = (y >= ym);
        oc[oc_bottom] = (y < 0);
        oc[oc_right] = (x >= xm);
        oc[oc_left] = (x < 0);
        return oc;
    endfunction

endpackage

// File: logic/clip_scan_timer.sv
`timescale 1ns/1ps

module clip_scan_timer (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] obj_map,
    input  logic        changed,
    input  logic        writing,
    input  logic        f0_full,
    output logic [4:0]  addr,
    output logic        read_en,
    output logic        load_strobe,
    output logic        start_refresh,
    output logic        end_refresh,
    output logic        clr_changed
);

    logic busy;
    logic slot;  // 0 = slot a (read), 1 = slot b (load)

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            slot <= 1'b0;
            addr <= 5'd0;
            start_refresh <= 1'b0;
            end_refresh <= 1'b0;
            load_strobe <= 1'b0;
        end else begin
            start_refresh <= !busy && changed && !writing;
            end_refresh <= 1'b0;
            load_strobe <= read_en;  // only when a record was actually read
            if (!busy) begin
                if (changed && !writing) begin
                    busy <= 1'b1;
                    addr <= 5'd0;
                    slot <= 1'b0;
                end
            end else if (!slot) begin
                if (!f0_full)
                    slot <= 1'b1;  // hold address while queue is full
            end else begin
                slot <= 1'b0;
                if (addr == 5'd31) begin
                    busy <= 1'b0;
                    end_refresh <= 1'b1;
                end else begin
                    addr <= addr + 5'd1;
                end
            end
        end
    end

    // clear map bits still burn their two slots
    assign read_en = busy && !slot && !f0_full && obj_map[addr];
    assign clr_changed = start_refresh;

endmodule

// File: logic/clip_line_loader.sv
`timescale 1ns/1ps

module clip_line_loader #(
    parameter int x_max = 640,
    parameter int y_max = 480
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [clip_pkg::obj_w-1:0]  obj,
    input  logic                        load_strobe,
    input  logic                        start_refresh,
    output logic [clip_pkg::ent_w-1:0]  f0_data,
    output logic                        f0_wr,
    output logic                        clr_f0
);

    localparam int cw = clip_pkg::coord_w;

    logic signed [cw-1:0] x0, y0, x1, y1;
    logic [3:0] oc0, oc1;

    assign x0 = obj[0 +: cw];
    assign y0 = obj[cw +: cw];
    assign x1 = obj[2*cw +: cw];
    assign y1 = obj[3*cw +: cw];

    assign oc0 = clip_pkg::outcode(x0, y0, x_max, y_max);
    assign oc1 = clip_pkg::outcode(x1, y1, x_max, y_max);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            f0_wr <= 1'b0;
        else
            f0_wr <= load_strobe;
    end

    // obj is valid in slot b, strobe marks a set map bit
    always_ff @(posedge clk) begin
        if (load_strobe)
            f0_data <= {oc1, oc0, obj};
    end

    assign clr_f0 = start_refresh;  // fresh queue per refresh

endmodule

// File: logic/clip_fifo.sv
`timescale 1ns/1ps

module clip_fifo #(
    parameter int width = 8,
    parameter int depth = 32
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr,
    input  logic             rd,
    input  logic             clr,
    input  logic [width-1:0] din,
    output logic [width-1:0] dout,
    output logic             empty,
    output logic             full
);

    localparam int aw = $clog2(depth);

    logic [width-1:0] mem [depth];
    logic [aw-1:0] wp, rp;
    logic [aw:0] count;
    logic do_wr, do_rd;

    assign empty = (count == 0);
    assign full = (count == depth);
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wp <= '0;
            rp <= '0;
            count <= '0;
        end else if (clr) begin
            wp <= '0;
            rp <= '0;
            count <= '0;
        end else begin
            if (do_wr)
                wp <= wp + 1'b1;  // depth is a power of two
            if (do_rd)
                rp <= rp + 1'b1;
            case ({do_wr, do_rd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wp] <= din;
        if (do_rd)
            dout <= mem[rp];  // registered read port
    end

endmodule

// File: logic/clip_control.sv
`timescale 1ns/1ps

module clip_control (
    input  logic clk,
    input  logic rst_n,
    input  logic f0_empty,
    input  logic f1_full,
    input  logic accept_line,
    input  logic reject_line,
    input  logic clip_line,
    input  logic clip_done,
    output logic f0_rd,
    output logic latch_line,
    output logic clip_en,
    output logic store_line,
    output logic reading,
    output logic idle
);

    clip_pkg::ctrl_state_t state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= clip_pkg::st_idle;
            latch_line <= 1'b0;
        end else begin
            latch_line <= (state == clip_pkg::st_pop);  // queue data lands a cycle after pop
            case (state)
                clip_pkg::st_idle:
                    if (!f0_empty)
                        state <= clip_pkg::st_pop;
                clip_pkg::st_pop:
                    state <= clip_pkg::st_judge;
                clip_pkg::st_judge:
                    // first cycle is the latch, verdict comes on the second
                    if (!latch_line) begin
                        if (accept_line)
                            state <= clip_pkg::st_store;
                        else if (reject_line)
                            state <= clip_pkg::st_drop;
                        else
                            state <= clip_pkg::st_clip;
                    end
                clip_pkg::st_clip:
                    if (clip_done)
                        state <= reject_line ? clip_pkg::st_drop : clip_pkg::st_store;
                clip_pkg::st_store:
                    if (!f1_full)
                        state <= clip_pkg::st_idle;
                clip_pkg::st_drop:
                    state <= clip_pkg::st_idle;
                default:
                    state <= clip_pkg::st_idle;
            endcase
        end
    end

    assign f0_rd = (state == clip_pkg::st_pop);
    assign clip_en = (state == clip_pkg::st_judge) && !latch_line && clip_line;
    assign store_line = (state == clip_pkg::st_store) && !f1_full;
    assign reading = (state != clip_pkg::st_idle);
    assign idle = (state == clip_pkg::st_idle);

endmodule

// File: logic/clip_engine.sv
`timescale 1ns/1ps

module clip_engine #(
    parameter int x_max = 640,
    parameter int y_max = 480
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [clip_pkg::ent_w-1:0]  f0_dout,
    input  logic                        latch_line,
    input  logic                        clip_en,
    input  logic                        store_line,
    output logic [clip_pkg::out_w-1:0]  f1_din,
    output logic                        f1_wr,
    output logic                        accept_line,
    output logic                        reject_line,
    output logic                        clip_line,
    output logic                        clip_done
);

    localparam int cw = clip_pkg::coord_w;
    localparam int pw = clip_pkg::pix_w;
    localparam logic signed [31:0] x_hi = x_max - 1;
    localparam logic signed [31:0] y_hi = y_max - 1;

    clip_pkg::clip_step_t step;
    logic [5:0] cnt;

    // working line
    logic signed [cw-1:0] x0, y0, x1, y1;
    logic [clip_pkg::color_w-1:0] color;
    logic [3:0] oc0, oc1;

    // setup
    logic [3:0] oc_sel;
    logic [1:0] e_c, edge_bit;
    logic sel;  // 1 moves endpoint 1
    logic signed [31:0] dx, dy, bx, by, num_c, den_c, num, den;

    // divider
    logic [31:0] quo, dvs;
    logic [32:0] rem, rem_sh, rem_sub;
    logic q_neg;
    logic signed [31:0] quotient;

    // update
    logic signed [cw-1:0] nx, ny;
    logic is_y;

    assign accept_line = ((oc0 | oc1) == 4'd0);
    assign reject_line = ((oc0 & oc1) != 4'd0);
    assign clip_line = !accept_line && !reject_line;
    assign clip_done = (step == clip_pkg::step_setup) && !clip_line;

    always_comb begin
        oc_sel = (oc0 != 4'd0) ? oc0 : oc1;  // endpoint 0 first
        if (oc_sel[clip_pkg::oc_top])
            e_c = clip_pkg::oc_top;
        else if (oc_sel[clip_pkg::oc_bottom])
            e_c = clip_pkg::oc_bottom;
        else if (oc_sel[clip_pkg::oc_right])
            e_c = clip_pkg::oc_right;
        else
            e_c = clip_pkg::oc_left;
        dx = x1 - x0;
        dy = y1 - y0;
        bx = (e_c == clip_pkg::oc_right) ? x_hi : 32'sd0;
        by = (e_c == clip_pkg::oc_top) ? y_hi : 32'sd0;
        if (e_c == clip_pkg::oc_top || e_c == clip_pkg::oc_bottom) begin
            num_c = dx * (by - y0);
            den_c = dy;
        end else begin
            num_c = dy * (bx - x0);
            den_c = dx;
        end
    end

    // restoring division on magnitudes
    assign rem_sh = {rem[31:0], quo[31]};
    assign rem_sub = rem_sh - {1'b0, dvs};
    assign quotient = q_neg ? -$signed(quo) : $signed(quo);  // truncates toward zero

    assign is_y = (edge_bit == clip_pkg::oc_top) || (edge_bit == clip_pkg::oc_bottom);
    always_comb begin
        if (is_y) begin
            nx = x0 + quotient[cw-1:0];
            ny = (edge_bit == clip_pkg::oc_top) ? y_hi[cw-1:0] : '0;
        end else begin
            nx = (edge_bit == clip_pkg::oc_right) ? x_hi[cw-1:0] : '0;
            ny = y0 + quotient[cw-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step <= clip_pkg::step_idle;
            cnt <= 6'd0;
            f1_wr <= 1'b0;
        end else begin
            f1_wr <= store_line;
            case (step)
                clip_pkg::step_idle:
                    if (clip_en)
                        step <= clip_pkg::step_setup;
                clip_pkg::step_setup:
                    if (clip_line) begin
                        step <= clip_pkg::step_divide;
                        cnt <= 6'd0;
                    end else begin
                        step <= clip_pkg::step_idle;
                    end
                clip_pkg::step_divide: begin
                    cnt <= cnt + 6'd1;
                    if (cnt == 6'd32)
                        step <= clip_pkg::step_update;
                end
                default:
                    step <= clip_pkg::step_setup;  // recheck outcodes after a move
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (latch_line) begin
            x0 <= f0_dout[0 +: cw];
            y0 <= f0_dout[cw +: cw];
            x1 <= f0_dout[2*cw +: cw];
            y1 <= f0_dout[3*cw +: cw];
            color <= f0_dout[4*cw +: clip_pkg::color_w];
            oc0 <= f0_dout[clip_pkg::obj_w +: 4];
            oc1 <= f0_dout[clip_pkg::obj_w + 4 +: 4];
        end
        if (step == clip_pkg::step_setup) begin
            sel <= (oc0 == 4'd0);
            edge_bit <= e_c;
            num <= num_c;
            den <= den_c;
        end
        if (step == clip_pkg::step_divide) begin
            if (cnt == 6'd0) begin
                quo <= num[31] ? -num : num;
                dvs <= den[31] ? -den : den;
                rem <= 33'd0;
                q_neg <= num[31] ^ den[31];
            end else if (!rem_sub[32]) begin
                rem <= rem_sub;
                quo <= {quo[30:0], 1'b1};
            end else begin
                rem <= rem_sh;
                quo <= {quo[30:0], 1'b0};
            end
        end
        if (step == clip_pkg::step_update) begin
            if (sel) begin
                x1 <= nx;
                y1 <= ny;
                oc1 <= clip_pkg::outcode(nx, ny, x_max, y_max);
            end else begin
                x0 <= nx;
                y0 <= ny;
                oc0 <= clip_pkg::outcode(nx, ny, x_max, y_max);
            end
        end
        if (store_line)
            f1_din <= {color, y1[pw-1:0], x1[pw-1:0], y0[pw-1:0], x0[pw-1:0]};
    end

endmodule

// File: logic/clip_top.sv
`timescale 1ns/1ps

module clip_top #(
    parameter int x_max = 640,
    parameter int y_max = 480,
    parameter int depth = 32
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [31:0]                    obj_map,
    input  logic [clip_pkg::obj_w-1:0]     obj,
    input  logic                           changed,
    input  logic                           writing,
    input  logic                           raster_ready,
    output logic [4:0]                     addr,
    output logic                           read_en,
    output logic                           clr_changed,
    output logic                           reading,
    output logic [clip_pkg::pix_w-1:0]     x0_out,
    output logic [clip_pkg::pix_w-1:0]     y0_out,
    output logic [clip_pkg::pix_w-1:0]     x1_out,
    output logic [clip_pkg::pix_w-1:0]     y1_out,
    output logic [clip_pkg::color_w-1:0]   color_out,
    output logic                           vld,
    output logic                           end_of_obj
);

    localparam int pw = clip_pkg::pix_w;

    logic load_strobe, start_refresh, end_refresh, refresh_done;
    logic [clip_pkg::ent_w-1:0] f0_data, f0_dout;
    logic f0_wr, f0_rd, clr_f0, f0_empty, f0_full;
    logic [clip_pkg::out_w-1:0] f1_din, f1_dout;
    logic f1_wr, f1_rd, f1_empty, f1_full;
    logic latch_line, clip_en, store_line, idle;
    logic accept_line, reject_line, clip_line, clip_done;

    clip_scan_timer u_timer (
        .clk(clk), .rst_n(rst_n), .obj_map(obj_map), .changed(changed),
        .writing(writing), .f0_full(f0_full), .addr(addr), .read_en(read_en),
        .load_strobe(load_strobe), .start_refresh(start_refresh),
        .end_refresh(end_refresh), .clr_changed(clr_changed)
    );

    clip_line_loader #(.x_max(x_max), .y_max(y_max)) u_loader (
        .clk(clk), .rst_n(rst_n), .obj(obj), .load_strobe(load_strobe),
        .start_refresh(start_refresh), .f0_data(f0_data), .f0_wr(f0_wr), .clr_f0(clr_f0)
    );

    clip_fifo #(.width(clip_pkg::ent_w), .depth(depth)) initial_fifo (
        .clk(clk), .rst_n(rst_n), .wr(f0_wr), .rd(f0_rd), .clr(clr_f0),
        .din(f0_data), .dout(f0_dout), .empty(f0_empty), .full(f0_full)
    );

    clip_control u_control (
        .clk(clk), .rst_n(rst_n), .f0_empty(f0_empty), .f1_full(f1_full),
        .accept_line(accept_line), .reject_line(reject_line), .clip_line(clip_line),
        .clip_done(clip_done), .f0_rd(f0_rd), .latch_line(latch_line), .clip_en(clip_en),
        .store_line(store_line), .reading(reading), .idle(idle)
    );

    clip_engine #(.x_max(x_max), .y_max(y_max)) u_engine (
        .clk(clk), .rst_n(rst_n), .f0_dout(f0_dout), .latch_line(latch_line),
        .clip_en(clip_en), .store_line(store_line), .f1_din(f1_din), .f1_wr(f1_wr),
        .accept_line(accept_line), .reject_line(reject_line), .clip_line(clip_line),
        .clip_done(clip_done)
    );

    // output queue survives refreshes, the rasterizer drains it
    clip_fifo #(.width(clip_pkg::out_w), .depth(depth)) final_fifo (
        .clk(clk), .rst_n(rst_n), .wr(f1_wr), .rd(f1_rd), .clr(1'b0),
        .din(f1_din), .dout(f1_dout), .empty(f1_empty), .full(f1_full)
    );

    assign x0_out = f1_dout[0 +: pw];
    assign y0_out = f1_dout[pw +: pw];
    assign x1_out = f1_dout[2*pw +: pw];
    assign y1_out = f1_dout[3*pw +: pw];
    assign color_out = f1_dout[4*pw +: clip_pkg::color_w];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            f1_rd <= 1'b0;
            vld <= 1'b0;
        end else begin
            // empty flag lags a read by a cycle, so never read twice in a row
            f1_rd <= raster_ready && !f1_empty && !f1_rd;
            vld <= f1_rd;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            refresh_done <= 1'b0;
            end_of_obj <= 1'b0;
        end else if (start_refresh) begin
            refresh_done <= 1'b0;
            end_of_obj <= 1'b0;
        end else begin
            if (end_refresh)
                refresh_done <= 1'b1;
            if (refresh_done && idle && f0_empty && f1_empty && !f1_wr)
                end_of_obj <= 1'b1;
        end
    end

endmodule

// File: sim/clip_props.sv
`timescale 1ns/1ps

module clip_props (
    input logic clk,
    input logic rst_n,
    input logic f1_rd,
    input logic f1_empty,
    input logic vld,
    input logic read_en,
    input logic start_refresh,
    input logic end_refresh,
    input logic clr_changed
);

    logic in_refresh;
    int fail_count = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            in_refresh <= 1'b0;
        else if (start_refresh)
            in_refresh <= 1'b1;
        else if (end_refresh)
            in_refresh <= 1'b0;
    end

    // a read strobe only ever hits a queue that holds data
    vld_after_rd: assert property (@(posedge clk) disable iff (!rst_n)
        vld == $past(f1_rd && !f1_empty))
        else begin
            fail_count++;
            $error("vld is not one cycle after a read of a non-empty queue");
        end

    // the first read slot shares its cycle with start_refresh
    no_read_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        read_en |-> (start_refresh || in_refresh))
        else begin
            fail_count++;
            $error("read_en high outside a refresh");
        end

    clr_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        clr_changed |=> !clr_changed)
        else begin
            fail_count++;
            $error("clr_changed longer than one cycle");
        end

endmodule

bind clip_top clip_props u_props (
    .clk(clk), .rst_n(rst_n), .f1_rd(f1_rd), .f1_empty(f1_empty), .vld(vld),
    .read_en(read_en), .start_refresh(start_refresh), .end_refresh(end_refresh),
    .clr_changed(clr_changed)
);

// File: sim/clip_tb.sv
`timescale 1ns/1ps

module clip_tb;

    localparam int x_max = 640;
    localparam int y_max = 480;
    localparam int depth = 32;
    localparam int pw = clip_pkg::pix_w;
    localparam int cw = clip_pkg::coord_w;

    logic clk;
    logic rst_n;
    logic [31:0] obj_map;
    logic [clip_pkg::obj_w-1:0] obj;
    logic changed;
    logic writing;
    logic raster_ready;
    logic [4:0] addr;
    logic read_en;
    logic clr_changed;
    logic reading;
    logic [pw-1:0] x0_out, y0_out, x1_out, y1_out;
    logic [clip_pkg::color_w-1:0] color_out;
    logic vld;
    logic end_of_obj;

    logic [67:0] tv [0:191];  // word 0 is the test count, then 64 words per test
    logic [67:0] exp_line;
    integer seed;
    integer rnd;
    int base;
    int exp_total;
    int out_idx;
    int read_count;
    int clr_count;
    int mismatches;
    int other_errs;
    bit timed_out;

    clip_top #(.x_max(x_max), .y_max(y_max), .depth(depth)) dut (
        .clk(clk), .rst_n(rst_n), .obj_map(obj_map), .obj(obj), .changed(changed),
        .writing(writing), .raster_ready(raster_ready), .addr(addr), .read_en(read_en),
        .clr_changed(clr_changed), .reading(reading), .x0_out(x0_out), .y0_out(y0_out),
        .x1_out(x1_out), .y1_out(y1_out), .color_out(color_out), .vld(vld),
        .end_of_obj(end_of_obj)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH at %0t ns: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic finish_run();
        int prop_errs;
        prop_errs = dut.u_props.fail_count;
        $display("errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatches, other_errs, prop_errs);
        if (mismatches == 0 && other_errs == 0 && prop_errs == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns: no %s", $time, what);
        other_errs++;
        timed_out = 1'b1;
    endtask

    // object memory with one cycle of latency, rasterizer and scoreboard
    always @(posedge clk) begin
        rnd = $random(seed);
        raster_ready <= rnd[0] | rnd[1];  // ready about 3 cycles in 4
        if (read_en) begin
            obj <= tv[base + 32 + addr][clip_pkg::obj_w-1:0];
            check("obj_map[addr]", 1, obj_map[addr]);
            read_count++;
        end
        if (clr_changed) begin
            clr_count++;
            changed <= 1'b0;
        end
        if (vld) begin
            if (out_idx >= exp_total) begin
                $display("line at %0t ns is beyond the expected %0d lines", $time, exp_total);
                other_errs++;
            end else begin
                exp_line = tv[base + 2 + out_idx];
                check("x0_out", exp_line[0 +: pw], x0_out);
                check("y0_out", exp_line[cw +: pw], y0_out);
                check("x1_out", exp_line[2*cw +: pw], x1_out);
                check("y1_out", exp_line[3*cw +: pw], y1_out);
                check("color_out", exp_line[4*cw +: clip_pkg::color_w], color_out);
            end
            out_idx++;
        end
    end

    task automatic run_refresh(input int t, input bit hold);
        int blk;
        int clr_before;
        int reads_before;
        int cycles;
        bit saw_reading;
        blk = 64 * (t + 1);
        @(posedge clk);
        base <= blk;
        obj_map <= tv[blk][31:0];
        exp_total <= tv[blk + 1][31:0];
        out_idx <= 0;
        changed <= 1'b1;
        writing <= hold;
        clr_before = clr_count;
        reads_before = read_count;
        if (hold) begin
            repeat (20) begin
                @(posedge clk);
                check("read_en", 0, read_en);
                check("clr_changed", 0, clr_changed);
            end
            writing <= 1'b0;
        end
        cycles = 0;
        while (!clr_changed && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (!clr_changed) begin
            report_timeout("clr_changed after the refresh request");
            return;
        end
        @(posedge clk);
        check("end_of_obj", 0, end_of_obj);  // new refresh clears it
        cycles = 0;
        saw_reading = 1'b0;
        while (!end_of_obj && cycles < 8000) begin
            @(posedge clk);
            if (reading)
                saw_reading = 1'b1;
            cycles++;
        end
        if (!end_of_obj) begin
            report_timeout("end_of_obj after the refresh");
            return;
        end
        check("reading", 0, reading);  // control back in idle
        check("reading seen", obj_map != 32'd0, saw_reading);
        check("line count", exp_total, out_idx);
        check("read count", $countones(obj_map), read_count - reads_before);
        check("clr_changed pulses", 1, clr_count - clr_before);
    endtask

    initial begin
        int n_tests;
        rst_n = 1'b0;
        obj_map = 32'd0;
        obj = '0;
        changed = 1'b0;
        writing = 1'b0;
        raster_ready = 1'b0;
        seed = 32'hc902_7a56;
        base = 64;
        exp_total = 0;
        out_idx = 0;
        read_count = 0;
        clr_count = 0;
        mismatches = 0;
        other_errs = 0;
        timed_out = 1'b0;
        $readmemh("sim/clip_tests.txt", tv);
        n_tests = tv[0][7:0];
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check("end_of_obj", 0, end_of_obj);
        check("reading", 0, reading);
        for (int t = 0; t < n_tests && !timed_out; t++)
            run_refresh(t, t > 0);  // later refreshes start under writing
        finish_run();
    end

endmodule

// File: sim/clip_tests.txt
// word 0 test count; test t at 64*(t+1): map, expected count, expected lines, record a at +32+a
// lines and records: colour, y1, x1, y0, x0 with 16-bit two's complement coordinates
@0
2
@40
3f
4
10190012c0014000a
30064027f00640064
400fa006400960000
500280081000000aa
@60
10190012c0014000a
2012c0320000a02bc
3006402bc00640064
400fa00640032ff9c
500280081ffe200c8
602bc00640190ff9c
@80
80000618
4
70027027f01c70000
10000000001df027f
301df014000f00140
4012c019000b4027f
@a3
7ffd802f80208ff9c
10000000001df027f
@a9
2ffff0258fffb000a
30384014000f00140
@bf
4012c019000640320

// File: compile.f
logic/clip_pkg.sv
logic/clip_scan_timer.sv
logic/clip_line_loader.sv
logic/clip_fifo.sv
logic/clip_control.sv
logic/clip_engine.sv
logic/clip_top.sv
sim/clip_props.sv
sim/clip_tb.sv
